/* dv/execMemTb.sv */
`timescale 1ns/1ps

module execMemTb;
    import pipePkg::*;

    localparam int CycleLimit = 3000;
    // Longest single wait is one multiply plus the two register stages
    localparam int WaitLimit  = MulIterations + 8;

    logic                    CLK;
    logic                    Reset;
    logic                    IssueValid;
    aluOpT                   Op;
    logic [DataWidth-1:0]    OperandA;
    logic [DataWidth-1:0]    OperandB;
    logic [DataWidth-1:0]    StoreData;
    logic                    RegWrite;
    logic                    MemWrite;
    logic                    MemtoReg;
    logic [RegAddrWidth-1:0] Wa3;
    logic [RegAddrWidth-1:0] Wa5;
    logic [RegAddrWidth-1:0] Ra2;
    logic                    IssueReady;
    logic                    RegWriteW;
    logic                    RegWrite2W;
    logic [RegAddrWidth-1:0] Wa3W;
    logic [RegAddrWidth-1:0] Wa5W;
    logic [DataWidth-1:0]    ResultW;
    logic [DataWidth-1:0]    HighW;

    // Shadow register file and data memory
    logic [DataWidth-1:0]    shadowReg [1 << RegAddrWidth];
    logic [DataWidth-1:0]    shadowMem [MemDepth];

    logic [15:0]             lfsrState;
    int                      mismatchCount;
    int                      failureCount;
    int                      cycleCount;
    int                      acceptCount;

    execMemTop execMemTop_i (.*);

    bind execMemTop execMemTopAssert execMemTopAssert_i (
        .CLK(CLK),
        .Reset(Reset),
        .IssueReady(IssueReady),
        .RegWriteW(RegWriteW),
        .RegWrite2W(RegWrite2W)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", CycleLimit);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic checkWord(input string testName, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", testName, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkAddr(input string testName, input logic [RegAddrWidth-1:0] expected,
                             input logic [RegAddrWidth-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected r%0d, actual r%0d", testName, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected flag %b, actual %b", testName, expected, actual);
            mismatchCount++;
        end
    endtask

    //////////////////////////////
    // Reference rules and LFSR
    //////////////////////////////
    function automatic logic [DataWidth-1:0] expectedAlu(input aluOpT op,
                                                         input logic [DataWidth-1:0] a,
                                                         input logic [DataWidth-1:0] b);
        case (op)
            AluAdd:  return a + b;
            AluSub:  return a - b;
            AluAnd:  return a & b;
            AluOrr:  return a | b;
            AluEor:  return a ^ b;
            AluMov:  return b;
            default: return '0;
        endcase
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic takeBits(input int count, output logic [DataWidth-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[DataWidth-2:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////
    task automatic driveIdle();
        IssueValid = 1'b0;
        Op         = AluAdd;
        OperandA   = '0;
        OperandB   = '0;
        StoreData  = '0;
        RegWrite   = 1'b0;
        MemWrite   = 1'b0;
        MemtoReg   = 1'b0;
        Wa3        = '0;
        Wa5        = '0;
        Ra2        = '0;
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge CLK);
        #2;
    endtask

    // Holds the operation until taken, or through the busy period when asked
    task automatic issueOp(input aluOpT op, input logic [DataWidth-1:0] a, b, store,
                           input logic regWr, memWr, memToReg,
                           input logic [RegAddrWidth-1:0] wa3v, wa5v, ra2v,
                           input bit holdWhileBusy);
        logic taken;
        int   waited;
        int   heldCycles;
        Op          = op;
        OperandA    = a;
        OperandB    = b;
        StoreData   = store;
        RegWrite    = regWr;
        MemWrite    = memWr;
        MemtoReg    = memToReg;
        Wa3         = wa3v;
        Wa5         = wa5v;
        Ra2         = ra2v;
        IssueValid  = 1'b1;
        acceptCount = 0;
        waited      = 0;
        heldCycles  = 0;
        do begin
            @(negedge CLK);
            taken = IssueValid && IssueReady;
            @(posedge CLK);
            #2;
            if (acceptCount > 0) heldCycles++;
            if (taken) acceptCount++;
            waited++;
        end while ((acceptCount == 0 || (holdWhileBusy && (heldCycles == 0 || !IssueReady)))
                   && waited < WaitLimit);
        driveIdle();
        if (acceptCount == 0) begin
            $display("Operation %s was never accepted", op.name());
            failureCount++;
        end
    endtask

    task automatic waitWriteback(input string testName);
        int waited;
        waited = 0;
        while (!RegWriteW && waited < WaitLimit) begin
            waitCycles(1);
            waited++;
        end
        if (!RegWriteW) begin
            $display("%s: no register write reached the writeback port", testName);
            failureCount++;
        end
    endtask

    //////////////////////////////
    // Operation tasks
    //////////////////////////////
    task automatic runAlu(input string testName, input aluOpT op,
                          input logic [DataWidth-1:0] a, b,
                          input logic [RegAddrWidth-1:0] dest);
        logic [DataWidth-1:0] expected;
        expected = expectedAlu(op, a, b);
        issueOp(op, a, b, '0, 1'b1, 1'b0, 1'b0, dest, '0, '0, 1'b0);
        waitWriteback(testName);
        checkWord(testName, expected, ResultW);
        checkAddr(testName, dest, Wa3W);
        checkFlag(testName, 1'b0, RegWrite2W);
        shadowReg[dest] = expected;
    endtask

    task automatic runMul(input string testName, input aluOpT op,
                          input logic [DataWidth-1:0] a, b,
                          input logic [RegAddrWidth-1:0] destLow, destHigh,
                          input bit holdWhileBusy);
        logic [2*DataWidth-1:0] product;
        product = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
        issueOp(op, a, b, '0, 1'b1, 1'b0, 1'b0, destLow, destHigh, '0, holdWhileBusy);
        if (acceptCount != 1) begin
            $display("%s: %0d operations accepted instead of one", testName, acceptCount);
            failureCount++;
        end
        waitWriteback(testName);
        checkWord(testName, product[DataWidth-1:0], ResultW);
        checkAddr(testName, destLow, Wa3W);
        checkFlag(testName, op == AluUmull, RegWrite2W);
        if (op == AluUmull) begin
            checkWord(testName, product[2*DataWidth-1:DataWidth], HighW);
            checkAddr(testName, destHigh, Wa5W);
        end
    endtask

    task automatic storeWord(input logic [DataWidth-1:0] base, offset, data);
        logic [DataWidth-1:0] addr;
        addr = base + offset;
        issueOp(AluAdd, base, offset, data, 1'b0, 1'b1, 1'b0, '0, '0, '0, 1'b0);
        shadowMem[addr[MemIndexWidth+1:2]] = data;
        waitCycles(2);
    endtask

    task automatic loadWord(input string testName, input logic [DataWidth-1:0] base, offset,
                            input logic [RegAddrWidth-1:0] dest);
        logic [DataWidth-1:0] addr;
        addr = base + offset;
        issueOp(AluAdd, base, offset, '0, 1'b1, 1'b0, 1'b1, dest, '0, '0, 1'b0);
        waitWriteback(testName);
        checkWord(testName, shadowMem[addr[MemIndexWidth+1:2]], ResultW);
        checkAddr(testName, dest, Wa3W);
        shadowReg[dest] = shadowMem[addr[MemIndexWidth+1:2]];
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic testAluOps();
        for (int i = 0; i < 6; i++) begin
            runAlu("aluOps", aluOpT'(3'(i)), 32'hF0F0_1234, 32'h0FF0_5678, 4'(i + 1));
        end
    endtask

    task automatic testMultiply();
        runMul("mul", AluMul, 32'hDEAD_BEEF, 32'h0001_2345, 4'd7, 4'd8, 1'b0);
        runMul("umull", AluUmull, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 4'd9, 4'd10, 1'b1);
        runMul("umull", AluUmull, 32'h8765_4321, 32'h0000_0003, 4'd11, 4'd12, 1'b1);
    endtask

    task automatic testStoreLoad();
        storeWord(32'h0000_003C, 32'h4, 32'hCAFE_0001);
        loadWord("storeLoad", 32'h0000_0040, 32'h0, 4'd3);
        storeWord(32'h0000_00F0, 32'hC, 32'h1357_9BDF);
        loadWord("storeLoad", 32'h0000_00F8, 32'h4, 4'd4);
    endtask

    // Load into r5, then a store of r5 right behind it with stale store data
    task automatic testForwarding();
        storeWord(32'h0000_0080, 32'h0, 32'h5A5A_1111);
        issueOp(AluAdd, 32'h0000_0080, 32'h0, '0, 1'b1, 1'b0, 1'b1, 4'd5, '0, '0, 1'b0);
        issueOp(AluAdd, 32'h0000_00C0, 32'h0, 32'hBAD0_0BAD, 1'b0, 1'b1, 1'b0,
                '0, '0, 4'd5, 1'b0);
        waitWriteback("forwardLoad");
        checkWord("forwardLoad", 32'h5A5A_1111, ResultW);
        shadowReg[5] = shadowMem[6'd32];
        shadowMem[6'd48] = shadowReg[5];
        waitCycles(2);
        loadWord("forwardStore", 32'h0000_00C0, 32'h0, 4'd6);
    endtask

    task automatic testRandomAlu();
        logic [DataWidth-1:0] opBits;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth-1:0] dest;
        repeat (40) begin
            takeBits(3, opBits);
            takeBits(DataWidth, a);
            takeBits(DataWidth, b);
            takeBits(RegAddrWidth, dest);
            runAlu("randomAlu", aluOpT'(3'(opBits % 6)), a, b, dest[RegAddrWidth-1:0]);
        end
    endtask

    initial begin
        driveIdle();
        Reset         = 1'b1;
        lfsrState     = 16'd4143;
        mismatchCount = 0;
        failureCount  = 0;
        repeat (16) @(posedge CLK);
        #2;
        Reset = 1'b0;
        waitCycles(1);
        checkFlag("reset", 1'b1, IssueReady);

        testAluOps();
        testMultiply();
        testStoreLoad();
        testForwarding();
        testRandomAlu();
        waitCycles(2);

        failureCount += execMemTop_i.execMemTopAssert_i.failCount;
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/execMemTop_assert.sv */
`timescale 1ns/1ps

module execMemTopAssert (
    input logic CLK,
    input logic Reset,
    input logic IssueReady,
    input logic RegWriteW,
    input logic RegWrite2W
);
    import pipePkg::*;

    int failCount = 0;
    int busyCycles;

    // Length of the current stall
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busyCycles <= 0;
        end else if (IssueReady) begin
            busyCycles <= 0;
        end else begin
            busyCycles <= busyCycles + 1;
        end
    end

    //////////////////////////////
    // Writeback and issue checks
    //////////////////////////////
    assert property (@(posedge CLK) disable iff (Reset) RegWrite2W |-> RegWriteW)
        else begin
            failCount++;
            $error("RegWrite2W high without RegWriteW");
        end

    assert property (@(posedge CLK) disable iff (Reset) busyCycles < MulIterations + 3)
        else begin
            failCount++;
            $error("IssueReady low for %0d cycles", busyCycles);
        end

    // First edge after reset release
    assert property (@(posedge CLK) $fell(Reset) |-> !RegWriteW && !RegWrite2W)
        else begin
            failCount++;
            $error("Write flags active right after reset");
        end

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  pipePkg::aluOpT                   Op,
    input  logic [pipePkg::DataWidth-1:0]    OperandA,
    input  logic [pipePkg::DataWidth-1:0]    OperandB,
    output logic [pipePkg::DataWidth-1:0]    Result
);
    import pipePkg::*;

    // Single-cycle operations only, the multiplier handles the rest
    always_comb begin
        case (Op)
            AluAdd: begin
                // Also forms the load/store address
                Result = OperandA + OperandB;
            end
            AluSub: begin
                Result = OperandA - OperandB;
            end
            AluAnd: begin
                Result = OperandA & OperandB;
            end
            AluOrr: begin
                Result = OperandA | OperandB;
            end
            AluEor: begin
                Result = OperandA ^ OperandB;
            end
            AluMov: begin
                Result = OperandB;
            end
            default: begin
                Result = '0;
            end
        endcase
    end

endmodule

/* hw/emBus.sv */
`timescale 1ns/1ps

interface emBus;
    import pipePkg::*;

    // Control flags
    logic                    RegWrite;
    logic                    RegWrite2;
    logic                    MemWrite;
    logic                    MemtoReg;

    // Data words
    logic [DataWidth-1:0]    AluResult;
    logic [DataWidth-1:0]    McResultHigh;
    logic [DataWidth-1:0]    WriteData;

    // Destination and store-source register addresses
    logic [RegAddrWidth-1:0] Wa3;
    logic [RegAddrWidth-1:0] Wa5;
    logic [RegAddrWidth-1:0] Ra2;

    modport src (
        output RegWrite, RegWrite2, MemWrite, MemtoReg,
        output AluResult, McResultHigh, WriteData,
        output Wa3, Wa5, Ra2
    );

    modport sink (
        input RegWrite, RegWrite2, MemWrite, MemtoReg,
        input AluResult, McResultHigh, WriteData,
        input Wa3, Wa5, Ra2
    );

endinterface

/* hw/emReg.sv */
`timescale 1ns/1ps

module emReg (
    input logic CLK,
    input logic Reset,
    emBus.sink  E,
    emBus.src   M
);

    // Free-running, no stall reaches this stage
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            M.RegWrite     <= 1'b0;
            M.RegWrite2    <= 1'b0;
            M.MemWrite     <= 1'b0;
            M.MemtoReg     <= 1'b0;
            M.AluResult    <= '0;
            M.McResultHigh <= '0;
            M.WriteData    <= '0;
            M.Wa3          <= '0;
            M.Wa5          <= '0;
            M.Ra2          <= '0;
        end else begin
            // Flags
            M.RegWrite     <= E.RegWrite;
            M.RegWrite2    <= E.RegWrite2;
            M.MemWrite     <= E.MemWrite;
            M.MemtoReg     <= E.MemtoReg;
            // Data
            M.AluResult    <= E.AluResult;
            M.McResultHigh <= E.McResultHigh;
            M.WriteData    <= E.WriteData;
            // Addresses
            M.Wa3          <= E.Wa3;
            M.Wa5          <= E.Wa5;
            M.Ra2          <= E.Ra2;
        end
    end

endmodule

/* hw/execMemTop.sv */
`timescale 1ns/1ps

module execMemTop (
    input  logic                             CLK,
    input  logic                             Reset,
    input  logic                             IssueValid,
    input  pipePkg::aluOpT                   Op,
    input  logic [pipePkg::DataWidth-1:0]    OperandA,
    input  logic [pipePkg::DataWidth-1:0]    OperandB,
    input  logic [pipePkg::DataWidth-1:0]    StoreData,
    input  logic                             RegWrite,
    input  logic                             MemWrite,
    input  logic                             MemtoReg,
    input  logic [pipePkg::RegAddrWidth-1:0] Wa3,
    input  logic [pipePkg::RegAddrWidth-1:0] Wa5,
    input  logic [pipePkg::RegAddrWidth-1:0] Ra2,
    output logic                             IssueReady,
    output logic                             RegWriteW,
    output logic                             RegWrite2W,
    output logic [pipePkg::RegAddrWidth-1:0] Wa3W,
    output logic [pipePkg::RegAddrWidth-1:0] Wa5W,
    output logic [pipePkg::DataWidth-1:0]    ResultW,
    output logic [pipePkg::DataWidth-1:0]    HighW
);
    import pipePkg::*;

    emBus busE ();
    emBus busM ();

    logic                    accept;
    logic                    aluIssue;
    logic                    mulLoad, mulStep, mulDone, mulLong, mulBusy, mulLast;
    logic [DataWidth-1:0]    aluResult;
    logic [DataWidth-1:0]    productLow, productHigh;
    logic [RegAddrWidth-1:0] heldWa3, heldWa5;

    assign accept     = IssueValid && IssueReady;
    assign aluIssue   = accept && !mulLoad;
    // One multiply in flight, nothing else issues meanwhile
    assign IssueReady = !mulBusy;

    aluUnit aluUnit_i (.Op(Op), .OperandA(OperandA), .OperandB(OperandB), .Result(aluResult));

    mulController mulController_i (
        .CLK(CLK), .Reset(Reset), .Start(accept), .Op(Op), .Last(mulLast),
        .Load(mulLoad), .Step(mulStep), .Done(mulDone), .Long(mulLong), .Busy(mulBusy)
    );

    mulCycleCounter mulCycleCounter_i (
        .CLK(CLK), .Reset(Reset), .Load(mulLoad), .Step(mulStep), .Last(mulLast)
    );

    mulDatapath mulDatapath_i (
        .CLK(CLK), .Reset(Reset), .Load(mulLoad), .Step(mulStep),
        .Multiplicand(OperandA), .Multiplier(OperandB),
        .ProductLow(productLow), .ProductHigh(productHigh)
    );

    // Destinations of the multiply, ports move on while it runs
    always_ff @(posedge CLK) begin
        if (mulLoad) begin
            heldWa3 <= Wa3;
            heldWa5 <= Wa5;
        end
    end

    ////////////////////////////////
    // Bubble and result select
    ////////////////////////////////
    always_comb begin
        busE.RegWrite     = 1'b0;
        busE.RegWrite2    = 1'b0;
        busE.MemWrite     = 1'b0;
        busE.MemtoReg     = 1'b0;
        busE.AluResult    = aluResult;
        busE.McResultHigh = '0;
        busE.WriteData    = StoreData;
        busE.Wa3          = Wa3;
        busE.Wa5          = Wa5;
        busE.Ra2          = Ra2;
        if (mulDone) begin
            busE.RegWrite     = 1'b1;
            busE.RegWrite2    = mulLong;
            busE.AluResult    = productLow;
            busE.McResultHigh = productHigh;
            busE.Wa3          = heldWa3;
            busE.Wa5          = heldWa5;
        end else if (aluIssue) begin
            busE.RegWrite = RegWrite;
            busE.MemWrite = MemWrite;
            busE.MemtoReg = MemtoReg;
        end
    end

    emReg emReg_i (.CLK(CLK), .Reset(Reset), .E(busE.sink), .M(busM.src));

    memStage memStage_i (
        .CLK(CLK), .Reset(Reset), .M(busM.sink),
        .RegWriteW(RegWriteW), .RegWrite2W(RegWrite2W), .Wa3W(Wa3W), .Wa5W(Wa5W),
        .ResultW(ResultW), .HighW(HighW)
    );

endmodule

/* hw/memStage.sv */
`timescale 1ns/1ps

module memStage (
    input  logic                             CLK,
    input  logic                             Reset,
    emBus.sink                               M,
    output logic                             RegWriteW,
    output logic                             RegWrite2W,
    output logic [pipePkg::RegAddrWidth-1:0] Wa3W,
    output logic [pipePkg::RegAddrWidth-1:0] Wa5W,
    output logic [pipePkg::DataWidth-1:0]    ResultW,
    output logic [pipePkg::DataWidth-1:0]    HighW
);
    import pipePkg::*;

    logic [DataWidth-1:0]     dataMem [MemDepth];
    logic [MemIndexWidth-1:0] memIndex;
    logic [DataWidth-1:0]     storeData;
    logic [DataWidth-1:0]     readData;

    // Word index, byte offset bits ignored
    assign memIndex = M.AluResult[MemIndexWidth+1:2];
    assign readData = dataMem[memIndex];

    // Store right behind the instruction that produced its source register
    assign storeData = (M.MemWrite && RegWriteW && (M.Ra2 == Wa3W)) ? ResultW : M.WriteData;

    always_ff @(posedge CLK) begin
        if (M.MemWrite) dataMem[memIndex] <= storeData;
    end

    ////////////////////////////////
    // Memory/writeback register
    ////////////////////////////////
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            RegWriteW  <= 1'b0;
            RegWrite2W <= 1'b0;
        end else begin
            RegWriteW  <= M.RegWrite;
            RegWrite2W <= M.RegWrite2;
        end
    end

    always_ff @(posedge CLK) begin
        Wa3W    <= M.Wa3;
        Wa5W    <= M.Wa5;
        ResultW <= M.MemtoReg ? readData : M.AluResult;
        HighW   <= M.McResultHigh;
    end

endmodule

/* hw/mulController.sv */
`timescale 1ns/1ps

module mulController (
    input  logic           CLK,
    input  logic           Reset,
    input  logic           Start,
    input  pipePkg::aluOpT Op,
    input  logic           Last,
    output logic           Load,
    output logic           Step,
    output logic           Done,
    output logic           Long,
    output logic           Busy
);
    import pipePkg::*;

    typedef enum logic [1:0] {
        StIdle,
        StRun,
        StDone
    } mulStateT;

    mulStateT state;
    mulStateT stateNext;
    logic     isMulOp;

    assign isMulOp = (Op == AluMul) || (Op == AluUmull);

    // Operands are captured on the accepting edge itself
    assign Load = Start && isMulOp && (state == StIdle);
    assign Step = (state == StRun);
    assign Done = (state == StDone);
    assign Busy = (state != StIdle);

    always_comb begin
        stateNext = state;
        case (state)
            StIdle: if (Load) stateNext = StRun;
            StRun:  if (Last) stateNext = StDone;
            default: stateNext = StIdle;
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= StIdle;
            Long  <= 1'b0;
        end else begin
            state <= stateNext;
            // UMULL enables the second register write
            if (Load) Long <= (Op == AluUmull);
        end
    end

endmodule

/* hw/mulCycleCounter.sv */
`timescale 1ns/1ps

module mulCycleCounter (
    input  logic CLK,
    input  logic Reset,
    input  logic Load,
    input  logic Step,
    output logic Last
);
    import pipePkg::*;

    logic [CountWidth-1:0] remaining;

    // Final step is the one taken while the count sits at one
    assign Last = (remaining == CountWidth'(1));

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            remaining <= '0;
        end else if (Load) begin
            remaining <= CountWidth'(MulIterations);
        end else if (Step) begin
            remaining <= remaining - CountWidth'(1);
        end
    end

endmodule

/* hw/mulDatapath.sv */
`timescale 1ns/1ps

module mulDatapath (
    input  logic                          CLK,
    input  logic                          Reset,
    input  logic                          Load,
    input  logic                          Step,
    input  logic [pipePkg::DataWidth-1:0] Multiplicand,
    input  logic [pipePkg::DataWidth-1:0] Multiplier,
    output logic [pipePkg::DataWidth-1:0] ProductLow,
    output logic [pipePkg::DataWidth-1:0] ProductHigh
);
    import pipePkg::*;

    logic [2*DataWidth-1:0] accumulator;
    logic [2*DataWidth-1:0] mcandShift;
    logic [DataWidth-1:0]   mplierShift;

    assign ProductLow  = accumulator[DataWidth-1:0];
    assign ProductHigh = accumulator[2*DataWidth-1:DataWidth];

    ////////////////////////////////
    // Operand shift registers
    ////////////////////////////////
    always_ff @(posedge CLK) begin
        if (Load) begin
            mcandShift  <= {{DataWidth{1'b0}}, Multiplicand};
            mplierShift <= Multiplier;
        end else if (Step) begin
            mcandShift  <= mcandShift << 1;
            mplierShift <= mplierShift >> 1;
        end
    end

    ////////////////////////////////
    // Partial product accumulation
    ////////////////////////////////
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            accumulator <= '0;
        end else if (Load) begin
            accumulator <= '0;
        end else if (Step && mplierShift[0]) begin
            // Unsigned, so no sign correction on the last step
            accumulator <= accumulator + mcandShift;
        end
    end

endmodule

/* hw/pipePkg.sv */
package pipePkg;

    ////////////////////////////////
    // Datapath sizes
    ////////////////////////////////
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 4;

    // Word-addressed data memory, index taken from AluResult[7:2]
    localparam int MemDepth      = 64;
    localparam int MemIndexWidth = $clog2(MemDepth);

    ////////////////////////////////
    // Iterative multiplier
    ////////////////////////////////
    localparam int MulIterations = 32;
    // Needs to hold the full iteration count, not just count-1
    localparam int CountWidth    = $clog2(MulIterations + 1);

    // Decoded operation as it arrives at execute
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOrr,
        AluEor,
        AluMov,
        AluMul,
        AluUmull
    } aluOpT;

endpackage

/* runSim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module execMemTb -Mdir obj_dir \
    && ./obj_dir/VexecMemTb > sim.log 2>&1
grep -qx "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }

/* src.f */
hw/pipePkg.sv
hw/emBus.sv
hw/aluUnit.sv
hw/mulController.sv
hw/mulCycleCounter.sv
hw/mulDatapath.sv
hw/emReg.sv
hw/memStage.sv
hw/execMemTop.sv
dv/execMemTop_assert.sv
dv/execMemTb.sv
